//--- Makefile
VERILATOR  ?= verilator
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_score_screen
RTL_TOP    := score_screen_top
FILELIST   := verilog.f
BUILD_DIR  := obj_dir
SIM_BIN    := $(BUILD_DIR)/V$(TOP)
SOURCES    := $(wildcard *.sv)
PASS_MSG   := Verification passed

.PHONY: all run lint clean

all: run

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -q "^$(PASS_MSG)$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

//--- digit_renderer.sv
`timescale 1ns/100ps
`default_nettype none

module digit_renderer #(
    parameter int DIGIT_X = score_screen_pkg::DIGIT_LEFT
) (
    input  score_screen_pkg::digit_t digit,
    input  vga_timing_pkg::coord_t   h_pos,
    input  vga_timing_pkg::coord_t   v_pos,
    output logic                     seg_hit
);

    // column edges
    localparam int X_MID   = DIGIT_X + score_screen_pkg::SEG_THICK;
    localparam int X_RIGHT = X_MID + score_screen_pkg::SEG_LEN;
    localparam int X_END   = X_RIGHT + score_screen_pkg::SEG_THICK;

    // row band edges, top bar down to bottom bar
    localparam int Y_UPPER = score_screen_pkg::DIGIT_TOP + score_screen_pkg::SEG_THICK;
    localparam int Y_MID   = Y_UPPER + score_screen_pkg::SEG_LEN;
    localparam int Y_LOWER = Y_MID + score_screen_pkg::SEG_THICK;
    localparam int Y_BOT   = Y_LOWER + score_screen_pkg::SEG_LEN;
    localparam int Y_END   = Y_BOT + score_screen_pkg::SEG_THICK;

    score_screen_pkg::segments_t segs;
    score_screen_pkg::segments_t in_seg;
    int   h;
    int   v;
    logic col_left, col_mid, col_right;
    logic row_top, row_upper, row_mid, row_lower, row_bot;

    // standard active-high pattern, a in the msb
    always_comb begin
        case (digit)
            4'd0:    segs = 7'b1111110;
            4'd1:    segs = 7'b0110000;
            4'd2:    segs = 7'b1101101;
            4'd3:    segs = 7'b1111001;
            4'd4:    segs = 7'b0110011;
            4'd5:    segs = 7'b1011011;
            4'd6:    segs = 7'b1011111;
            4'd7:    segs = 7'b1110000;
            4'd8:    segs = 7'b1111111;
            4'd9:    segs = 7'b1111011;
            default: segs = 7'b0000000;
        endcase
    end

    assign h = int'(h_pos);
    assign v = int'(v_pos);

    assign col_left  = (h >= DIGIT_X) && (h < X_MID);
    assign col_mid   = (h >= X_MID)   && (h < X_RIGHT);
    assign col_right = (h >= X_RIGHT) && (h < X_END);

    assign row_top   = (v >= score_screen_pkg::DIGIT_TOP) && (v < Y_UPPER);
    assign row_upper = (v >= Y_UPPER) && (v < Y_MID);
    assign row_mid   = (v >= Y_MID)   && (v < Y_LOWER);
    assign row_lower = (v >= Y_LOWER) && (v < Y_BOT);
    assign row_bot   = (v >= Y_BOT)   && (v < Y_END);

    // which segment box holds the pixel, same bit order as segs
    assign in_seg = {col_mid & row_top,     col_right & row_upper, col_right & row_lower,
                     col_mid & row_bot,     col_left & row_lower,  col_left & row_upper,
                     col_mid & row_mid};

    assign seg_hit = |(segs & in_seg);

endmodule

`default_nettype wire

//--- pixel_mixer.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_mixer (
    input  logic                                    clock,
    input  logic                                    rst_n,
    input  logic                                    active,
    input  logic                                    hsync,
    input  logic                                    vsync,
    input  logic [score_screen_pkg::DIGIT_COUNT-1:0] seg_hit,
    input  logic                                    text_hit,
    output logic [3:0]                              vga_r,
    output logic [3:0]                              vga_g,
    output logic [3:0]                              vga_b,
    output logic                                    vga_hs,
    output logic                                    vga_vs
);

    logic [3:0] level;

    // digits win over text, blanking forces black
    always_comb begin
        if (active && (|seg_hit)) begin
            level = score_screen_pkg::DIGIT_LEVEL;
        end else if (active && text_hit) begin
            level = score_screen_pkg::TEXT_LEVEL;
        end else begin
            level = 4'd0;
        end
    end

    // sync goes through the same register stage as the colour
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            vga_r  <= 4'd0;
            vga_g  <= 4'd0;
            vga_b  <= 4'd0;
            vga_hs <= 1'b1;
            vga_vs <= 1'b1;
        end else begin
            vga_r  <= level;
            vga_g  <= level;
            vga_b  <= level;
            vga_hs <= hsync;
            vga_vs <= vsync;
        end
    end

endmodule

`default_nettype wire

//--- score_digits.sv
`timescale 1ns/100ps
`default_nettype none

module score_digits (
    input  logic                                                    clock,
    input  logic                                                    rst_n,
    input  logic                                                    frame_start,
    input  score_screen_pkg::score_t                                score,
    output score_screen_pkg::digit_t [score_screen_pkg::DIGIT_COUNT-1:0] digits
);

    score_screen_pkg::score_t clamped;
    score_screen_pkg::score_t held;

    // anything past three digits saturates
    assign clamped = (score > score_screen_pkg::score_t'(score_screen_pkg::SCORE_MAX))
                   ? score_screen_pkg::score_t'(score_screen_pkg::SCORE_MAX)
                   : score;

    // sampled at the top of the frame only, so one frame never mixes two scores
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            held <= '0;
        end else if (frame_start) begin
            held <= clamped;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decimal split, position 0 is the ones digit
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < score_screen_pkg::DIGIT_COUNT; i++) begin : g_split
        assign digits[i] = score_screen_pkg::digit_t'((int'(held) / (10 ** i)) % 10);
    end

endmodule

`default_nettype wire

//--- score_screen_pkg.sv
`default_nettype none

package score_screen_pkg;

    //////////////////////////////////////////////////////////////////////
    // score and digit types
    //////////////////////////////////////////////////////////////////////

    localparam int DIGIT_COUNT = 3;
    localparam int SCORE_MAX   = 999;

    typedef logic [3:0]  digit_t;
    typedef logic [11:0] score_t;

    // a b c d e f g, top bar in bit 6
    typedef logic [6:0] segments_t;

    //////////////////////////////////////////////////////////////////////
    // digit geometry
    //////////////////////////////////////////////////////////////////////

    localparam int DIGIT_LEFT  = 210;
    localparam int DIGIT_PITCH = 75;
    localparam int DIGIT_TOP   = 215;
    localparam int SEG_THICK   = 10;
    localparam int SEG_LEN     = 50;

    //////////////////////////////////////////////////////////////////////
    // FINAL SCORE banner
    //////////////////////////////////////////////////////////////////////

    localparam int TEXT_LEN = 10;
    localparam int GLYPH_H  = 8;
    localparam int GLYPH_W  = 8;
    localparam int TEXT_TOP = 160;

    localparam int TEXT_X [TEXT_LEN] = '{240, 256, 272, 288, 304, 328, 344, 360, 376, 392};

    // F I N A L S C O R E, bit k is the pixel k to the right of the cell edge
    localparam logic [7:0] font_rows [TEXT_LEN][GLYPH_H] = '{
        '{8'b11111000, 8'b00001000, 8'b00001000, 8'b01111000,
          8'b00001000, 8'b00001000, 8'b00001000, 8'b00000000},
        '{8'b00111000, 8'b00010000, 8'b00010000, 8'b00010000,
          8'b00010000, 8'b00010000, 8'b00111000, 8'b00000000},
        '{8'b01000010, 8'b01000110, 8'b01001010, 8'b01010010,
          8'b01100010, 8'b01000010, 8'b01000010, 8'b00000000},
        '{8'b00111110, 8'b01000001, 8'b01000001, 8'b01111111,
          8'b01000001, 8'b01000001, 8'b01000001, 8'b00000000},
        '{8'b00000001, 8'b00000001, 8'b00000001, 8'b00000001,
          8'b00000001, 8'b00000001, 8'b00111111, 8'b00000000},
        '{8'b00111110, 8'b01000001, 8'b00000001, 8'b00111110,
          8'b01000000, 8'b01000001, 8'b00111110, 8'b00000000},
        '{8'b00111100, 8'b01000010, 8'b00000001, 8'b00000001,
          8'b00000001, 8'b01000010, 8'b00111100, 8'b00000000},
        '{8'b01111100, 8'b10000010, 8'b10000010, 8'b10000010,
          8'b10000010, 8'b10000010, 8'b01111100, 8'b00000000},
        '{8'b00011111, 8'b00100001, 8'b00100001, 8'b00011111,
          8'b00010001, 8'b00100001, 8'b01000001, 8'b00000000},
        '{8'b01111110, 8'b00000010, 8'b00000010, 8'b01111110,
          8'b00000010, 8'b00000010, 8'b01111110, 8'b00000000}
    };

    // grey levels, same on r, g and b
    localparam logic [3:0] DIGIT_LEVEL = 4'd15;
    localparam logic [3:0] TEXT_LEVEL  = 4'd9;

endpackage

`default_nettype wire

//--- score_screen_top.sv
`timescale 1ns/100ps
`default_nettype none

module score_screen_top #(
    parameter int H_ACTIVE = vga_timing_pkg::H_ACTIVE,
    parameter int H_FRONT  = vga_timing_pkg::H_FRONT,
    parameter int H_SYNC   = vga_timing_pkg::H_SYNC,
    parameter int H_BACK   = vga_timing_pkg::H_BACK,
    parameter int V_ACTIVE = vga_timing_pkg::V_ACTIVE,
    parameter int V_FRONT  = vga_timing_pkg::V_FRONT,
    parameter int V_SYNC   = vga_timing_pkg::V_SYNC,
    parameter int V_BACK   = vga_timing_pkg::V_BACK
) (
    input  logic                     clock,
    input  logic                     rst_n,
    input  score_screen_pkg::score_t score,
    output logic [3:0]               vga_r,
    output logic [3:0]               vga_g,
    output logic [3:0]               vga_b,
    output logic                     vga_hs,
    output logic                     vga_vs
);

    vga_timing_pkg::coord_t h_pos;
    vga_timing_pkg::coord_t v_pos;
    logic active, hsync, vsync, frame_start;
    logic text_hit;
    logic [score_screen_pkg::DIGIT_COUNT-1:0] seg_hit;
    score_screen_pkg::digit_t [score_screen_pkg::DIGIT_COUNT-1:0] digits;

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (
        .clock(clock), .rst_n(rst_n), .h_pos(h_pos), .v_pos(v_pos), .active(active),
        .hsync(hsync), .vsync(vsync), .frame_start(frame_start)
    );

    score_digits u_digits (
        .clock(clock), .rst_n(rst_n), .frame_start(frame_start), .score(score), .digits(digits)
    );

    // ones digit on the right, hundreds on the left
    for (genvar i = 0; i < score_screen_pkg::DIGIT_COUNT; i++) begin : g_digit
        digit_renderer #(
            .DIGIT_X(score_screen_pkg::DIGIT_LEFT
                     + (score_screen_pkg::DIGIT_COUNT - 1 - i) * score_screen_pkg::DIGIT_PITCH)
        ) u_render (
            .digit(digits[i]), .h_pos(h_pos), .v_pos(v_pos), .seg_hit(seg_hit[i])
        );
    end

    text_banner u_banner (.h_pos(h_pos), .v_pos(v_pos), .text_hit(text_hit));

    pixel_mixer u_mixer (
        .clock(clock), .rst_n(rst_n), .active(active), .hsync(hsync), .vsync(vsync),
        .seg_hit(seg_hit), .text_hit(text_hit), .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
        .vga_hs(vga_hs), .vga_vs(vga_vs)
    );

endmodule

`default_nettype wire

//--- tb_score_screen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_score_screen;

    localparam int CLK_PERIOD   = 10;
    localparam int DRIVE_DELAY  = 1;
    localparam int RESET_CYCLES = 2;
    localparam int RANDOM_SEED  = 95;
    localparam int H_TOTAL      = 800;
    localparam int V_TOTAL      = 525;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int RUN_FRAMES   = 6;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + RUN_FRAMES * FRAME_CYCLES + 2000;
    // score changes land before the digits and in the middle of them
    localparam int EARLY_LINE   = 50;
    localparam int MID_LINE     = 262;
    localparam int FIXED_SCORES [4] = '{0, 7, 999, 1234};
    localparam int LETTER_X [10] = '{240, 256, 272, 288, 304, 328, 344, 360, 376, 392};

    logic clock;
    logic rst_n;
    score_screen_pkg::score_t score;
    logic [3:0] vga_r;
    logic [3:0] vga_g;
    logic [3:0] vga_b;
    logic vga_hs;
    logic vga_vs;

    // raster model, the pixel the outputs carry right now
    logic  tracking;
    int    h_model;
    int    v_model;
    int    latched;
    int    score_prev;

    score_screen_top DUT (
        .clock(clock), .rst_n(rst_n), .score(score), .vga_r(vga_r), .vga_g(vga_g),
        .vga_b(vga_b), .vga_hs(vga_hs), .vga_vs(vga_vs)
    );

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_pixel_value(input string name, input logic [3:0] got,
                                     input logic [3:0] want);
        assert (got === want) else
            report_error($sformatf("Mismatch %s at h=%0d v=%0d: expected 0x%h, got 0x%h",
                                   name, h_model, v_model, want, got));
    endtask

    task automatic check_reset_value(input string name, input logic [3:0] got,
                                     input logic [3:0] want);
        assert (got === want) else
            report_error($sformatf("Mismatch %s after reset: expected 0x%h, got 0x%h",
                                   name, want, got));
    endtask

    //////////////////////////////////////////////////////////////////////
    // expected picture
    //////////////////////////////////////////////////////////////////////

    function automatic logic inside_box(input int h, v, x0, x1, y0, y1);
        return (h >= x0) && (h < x1) && (v >= y0) && (v < y1);
    endfunction

    // a..g from bit 6 down to bit 0
    function automatic logic [6:0] seven_seg(input int d);
        case (d)
            0:       return 7'h7E;
            1:       return 7'h30;
            2:       return 7'h6D;
            3:       return 7'h79;
            4:       return 7'h33;
            5:       return 7'h5B;
            6:       return 7'h5F;
            7:       return 7'h70;
            8:       return 7'h7F;
            9:       return 7'h7B;
            default: return 7'h00;
        endcase
    endfunction

    function automatic logic segment_pixel(input int h, v, x, input logic [6:0] segs);
        logic [6:0] hit;
        hit[6] = inside_box(h, v, x + 10, x + 60, 215, 225);
        hit[5] = inside_box(h, v, x + 60, x + 70, 225, 275);
        hit[4] = inside_box(h, v, x + 60, x + 70, 285, 335);
        hit[3] = inside_box(h, v, x + 10, x + 60, 335, 345);
        hit[2] = inside_box(h, v, x, x + 10, 285, 335);
        hit[1] = inside_box(h, v, x, x + 10, 225, 275);
        hit[0] = inside_box(h, v, x + 10, x + 60, 275, 285);
        return |(hit & segs);
    endfunction

    function automatic logic banner_pixel(input int h, v);
        logic bit_set;
        bit_set = 1'b0;
        if ((v >= 160) && (v < 168)) begin
            for (int i = 0; i < 10; i++) begin
                if ((h >= LETTER_X[i]) && (h < LETTER_X[i] + 8)) begin
                    bit_set = score_screen_pkg::font_rows[i][v - 160][h - LETTER_X[i]];
                end
            end
        end
        return bit_set;
    endfunction

    function automatic logic [3:0] expected_level(input int h, v, s);
        int shown;
        int digit_val [3];
        shown = (s > 999) ? 999 : s;
        digit_val[0] = shown % 10;
        digit_val[1] = (shown / 10) % 10;
        digit_val[2] = shown / 100;
        if ((h >= 640) || (v >= 480)) begin
            return 4'd0;
        end
        // position 0 is the ones digit, rightmost box
        for (int i = 0; i < 3; i++) begin
            if (segment_pixel(h, v, 210 + (2 - i) * 75, seven_seg(digit_val[i]))) begin
                return 4'd15;
            end
        end
        return banner_pixel(h, v) ? 4'd9 : 4'd0;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks, sampled mid-cycle while the outputs are stable
    //////////////////////////////////////////////////////////////////////

    // green and blue follow the red level checked at the negedge before
    channels_equal: assert property (@(posedge clock) disable iff (!rst_n)
        (vga_r == vga_g) && (vga_g == vga_b))
        else report_error($sformatf("Mismatch vga_g/vga_b: expected 0x%h, got 0x%h and 0x%h",
                                    $sampled(vga_r), $sampled(vga_g), $sampled(vga_b)));

    always @(negedge clock) begin
        logic [3:0] want;
        if (tracking) begin
            // the score seen at the edge that showed pixel 0 is held for the frame
            if ((h_model == 0) && (v_model == 0)) begin
                latched = score_prev;
            end
            want = expected_level(h_model, v_model, latched);
            check_pixel_value("vga_r", vga_r, want);
            check_pixel_value("vga_hs", {3'b000, vga_hs},
                              {3'b000, !((h_model >= 656) && (h_model < 752))});
            check_pixel_value("vga_vs", {3'b000, vga_vs},
                              {3'b000, !((v_model >= 490) && (v_model < 492))});
            if (h_model == H_TOTAL - 1) begin
                h_model = 0;
                v_model = (v_model == V_TOTAL - 1) ? 0 : v_model + 1;
            end else begin
                h_model++;
            end
        end
        score_prev = int'(score);
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_error("watchdog expired before the frames were complete");
    end

    initial begin
        void'($urandom(RANDOM_SEED));
        rst_n          = 1'b0;
        score          = score_screen_pkg::score_t'(FIXED_SCORES[0]);
        tracking       = 1'b0;
        h_model        = 0;
        v_model        = 0;
        latched        = 0;
        score_prev     = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        #(DRIVE_DELAY);
        rst_n = 1'b1;
        check_reset_value("vga_r", vga_r, 4'h0);
        check_reset_value("vga_g", vga_g, 4'h0);
        check_reset_value("vga_b", vga_b, 4'h0);
        check_reset_value("vga_hs", {3'b000, vga_hs}, 4'h1);
        check_reset_value("vga_vs", {3'b000, vga_vs}, 4'h1);
        // first edge out of reset puts pixel 0 on the outputs
        @(posedge clock);
        tracking = 1'b1;
        for (int f = 0; f < RUN_FRAMES; f++) begin
            repeat (EARLY_LINE * H_TOTAL) @(posedge clock);
            #(DRIVE_DELAY);
            score = score_screen_pkg::score_t'($urandom_range(1100, 0));
            repeat ((MID_LINE - EARLY_LINE) * H_TOTAL) @(posedge clock);
            #(DRIVE_DELAY);
            if (f < 3) begin
                score = score_screen_pkg::score_t'(FIXED_SCORES[f + 1]);
            end else begin
                score = score_screen_pkg::score_t'($urandom_range(1100, 0));
            end
            repeat ((V_TOTAL - MID_LINE) * H_TOTAL) @(posedge clock);
        end
        repeat (10) @(posedge clock);
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- text_banner.sv
`timescale 1ns/100ps
`default_nettype none

module text_banner (
    input  vga_timing_pkg::coord_t h_pos,
    input  vga_timing_pkg::coord_t v_pos,
    output logic                   text_hit
);

    localparam int TEXT_BOTTOM = score_screen_pkg::TEXT_TOP + score_screen_pkg::GLYPH_H;

    logic       in_rows;
    logic [2:0] row;

    assign in_rows = (int'(v_pos) >= score_screen_pkg::TEXT_TOP) && (int'(v_pos) < TEXT_BOTTOM);
    assign row     = 3'(int'(v_pos) - score_screen_pkg::TEXT_TOP);

    //////////////////////////////////////////////////////////////////////
    // letter cell lookup
    //////////////////////////////////////////////////////////////////////

    // cells do not overlap, so at most one letter matches
    always_comb begin
        int col;
        text_hit = 1'b0;
        for (int i = 0; i < score_screen_pkg::TEXT_LEN; i++) begin
            col = int'(h_pos) - score_screen_pkg::TEXT_X[i];
            if (in_rows && (col >= 0) && (col < score_screen_pkg::GLYPH_W)) begin
                text_hit = score_screen_pkg::font_rows[i][row][col[2:0]];
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
vga_timing_pkg.sv
score_screen_pkg.sv
vga_timing.sv
score_digits.sv
digit_renderer.sv
text_banner.sv
pixel_mixer.sv
score_screen_top.sv
tb_score_screen.sv

//--- vga_timing.sv
`timescale 1ns/100ps
`default_nettype none

module vga_timing #(
    parameter int H_ACTIVE = vga_timing_pkg::H_ACTIVE,
    parameter int H_FRONT  = vga_timing_pkg::H_FRONT,
    parameter int H_SYNC   = vga_timing_pkg::H_SYNC,
    parameter int H_BACK   = vga_timing_pkg::H_BACK,
    parameter int V_ACTIVE = vga_timing_pkg::V_ACTIVE,
    parameter int V_FRONT  = vga_timing_pkg::V_FRONT,
    parameter int V_SYNC   = vga_timing_pkg::V_SYNC,
    parameter int V_BACK   = vga_timing_pkg::V_BACK
) (
    input  logic                   clock,
    input  logic                   rst_n,
    output vga_timing_pkg::coord_t h_pos,
    output vga_timing_pkg::coord_t v_pos,
    output logic                   active,
    output logic                   hsync,
    output logic                   vsync,
    output logic                   frame_start
);

    // last count and sync window edges, sync end is exclusive
    localparam int H_LAST       = H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1;
    localparam int V_LAST       = V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1;
    localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
    localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;
    localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
    localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

    vga_timing_pkg::coord_t h_next;
    vga_timing_pkg::coord_t v_next;

    // next pixel, the line advances when a row wraps
    always_comb begin
        h_next = h_pos + 1'b1;
        v_next = v_pos;
        if (h_pos == vga_timing_pkg::coord_t'(H_LAST)) begin
            h_next = '0;
            if (v_pos == vga_timing_pkg::coord_t'(V_LAST)) begin
                v_next = '0;
            end else begin
                v_next = v_pos + 1'b1;
            end
        end
    end

    // flags are decoded from the next count so they line up with h_pos and v_pos
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            h_pos       <= '0;
            v_pos       <= '0;
            active      <= 1'b1;
            hsync       <= 1'b1;
            vsync       <= 1'b1;
            frame_start <= 1'b1;
        end else begin
            h_pos       <= h_next;
            v_pos       <= v_next;
            active      <= (int'(h_next) < H_ACTIVE) && (int'(v_next) < V_ACTIVE);
            hsync       <= !((int'(h_next) >= H_SYNC_START) && (int'(h_next) < H_SYNC_END));
            vsync       <= !((int'(v_next) >= V_SYNC_START) && (int'(v_next) < V_SYNC_END));
            frame_start <= (h_next == '0) && (v_next == '0);
        end
    end

endmodule

`default_nettype wire

//--- vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

    //////////////////////////////////////////////////////////////////////
    // raster position
    //////////////////////////////////////////////////////////////////////

    // wide enough for 800 pixels and 525 lines
    typedef logic [9:0] coord_t;

    //////////////////////////////////////////////////////////////////////
    // 640x480 at 60 Hz, in pixel clocks and lines
    //////////////////////////////////////////////////////////////////////

    // horizontal, one row
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_BACK   = 48;

    // vertical, one frame
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;

endpackage

`default_nettype wire
